// File: src/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

	// Basic LC-3b datapath types.
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp; // n, z, p from msb down.

	// Register file depth.
	localparam int num_regs = 8;

	// JSR and TRAP write the return address here.
	localparam lc3b_reg r7 = 3'd7;

	// Opcode field, bits 15 to 12.
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

endpackage : lc3b_isa_pkg

// File: src/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

	typedef enum logic [2:0]
	{
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	// Source-2 register number.
	typedef enum logic
	{
		src_ir_sr2 = 1'b0, // ir[2:0].
		src_ir_dr  = 1'b1  // ir[11:9], stores read their data register.
	} srcmux_sel;

	// Destination register number.
	typedef enum logic
	{
		dest_ir = 1'b0, // ir[11:9].
		dest_r7 = 1'b1  // Link register.
	} destmux_sel;

	typedef struct packed
	{
		lc3b_isa_pkg::lc3b_opcode opcode;
		lc3b_aluop aluop;
		srcmux_sel regfilemux_sel;
		destmux_sel destmux_sel;
		logic sr1_needed;
		logic sr2_needed;
		logic cc_needed;
		logic ld_reg;
		logic ld_cc;
		logic mem_read;
		logic mem_write;
		logic branch_stall;
	} lc3b_control_word;

endpackage : lc3b_ctrl_pkg

// File: src/hazard_if.sv
`timescale 1ns/1ps

// Destination status of the stages downstream of decode.
interface hazard_if (input logic clk);

	lc3b_isa_pkg::lc3b_reg ex_drid;
	logic ex_ld_reg;
	logic ex_ld_cc;
	logic ex_valid;

	lc3b_isa_pkg::lc3b_reg mem_drid;
	logic mem_ld_reg;
	logic mem_ld_cc;
	logic mem_valid;

	lc3b_isa_pkg::lc3b_reg wb_drid;
	logic wb_ld_reg;
	logic wb_ld_cc;
	logic wb_valid;

	modport producer
	(
		output ex_drid, ex_ld_reg, ex_ld_cc, ex_valid,
		output mem_drid, mem_ld_reg, mem_ld_cc, mem_valid,
		output wb_drid, wb_ld_reg, wb_ld_cc, wb_valid
	);

	modport consumer
	(
		input clk,
		input ex_drid, ex_ld_reg, ex_ld_cc, ex_valid,
		input mem_drid, mem_ld_reg, mem_ld_cc, mem_valid,
		input wb_drid, wb_ld_reg, wb_ld_cc, wb_valid
	);

endinterface : hazard_if

// File: src/control_rom.sv
`timescale 1ns/1ps

module control_rom
(
	input lc3b_isa_pkg::lc3b_word instr,
	output lc3b_ctrl_pkg::lc3b_control_word ctrl
);

lc3b_isa_pkg::lc3b_opcode opcode;

assign opcode = lc3b_isa_pkg::lc3b_opcode'(instr[15:12]);

always_comb
begin
	ctrl.opcode = opcode;
	ctrl.aluop = lc3b_ctrl_pkg::alu_add;
	ctrl.regfilemux_sel = lc3b_ctrl_pkg::src_ir_sr2;
	ctrl.destmux_sel = lc3b_ctrl_pkg::dest_ir;
	ctrl.sr1_needed = 1'b0;
	ctrl.sr2_needed = 1'b0;
	ctrl.cc_needed = 1'b0;
	ctrl.ld_reg = 1'b0;
	ctrl.ld_cc = 1'b0;
	ctrl.mem_read = 1'b0;
	ctrl.mem_write = 1'b0;
	ctrl.branch_stall = 1'b0;

	case (opcode)
		lc3b_isa_pkg::op_br:
		begin
			ctrl.cc_needed = 1'b1;
			ctrl.branch_stall = 1'b1;
		end
		lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and:
		begin
			ctrl.aluop = (opcode == lc3b_isa_pkg::op_and) ? lc3b_ctrl_pkg::alu_and
				: lc3b_ctrl_pkg::alu_add;
			ctrl.sr1_needed = 1'b1;
			ctrl.sr2_needed = ~instr[5]; // Immediate form has no sr2.
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end
		lc3b_isa_pkg::op_not:
		begin
			ctrl.aluop = lc3b_ctrl_pkg::alu_not;
			ctrl.sr1_needed = 1'b1;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end
		lc3b_isa_pkg::op_shf:
		begin
			if (!instr[4])
				ctrl.aluop = lc3b_ctrl_pkg::alu_sll;
			else if (!instr[5])
				ctrl.aluop = lc3b_ctrl_pkg::alu_srl;
			else
				ctrl.aluop = lc3b_ctrl_pkg::alu_sra;
			ctrl.sr1_needed = 1'b1;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end
		lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_ldi:
		begin
			ctrl.sr1_needed = 1'b1; // Base register.
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
			ctrl.mem_read = 1'b1;
		end
		lc3b_isa_pkg::op_stb, lc3b_isa_pkg::op_str, lc3b_isa_pkg::op_sti:
		begin
			ctrl.regfilemux_sel = lc3b_ctrl_pkg::src_ir_dr;
			ctrl.sr1_needed = 1'b1;
			ctrl.sr2_needed = 1'b1;
			ctrl.mem_write = 1'b1;
			ctrl.mem_read = (opcode == lc3b_isa_pkg::op_sti); // Pointer fetch first.
		end
		lc3b_isa_pkg::op_jsr:
		begin
			ctrl.aluop = lc3b_ctrl_pkg::alu_pass;
			ctrl.destmux_sel = lc3b_ctrl_pkg::dest_r7;
			ctrl.sr1_needed = ~instr[11]; // JSRR jumps through BaseR.
			ctrl.ld_reg = 1'b1;
			ctrl.branch_stall = 1'b1;
		end
		lc3b_isa_pkg::op_jmp:
		begin
			ctrl.aluop = lc3b_ctrl_pkg::alu_pass;
			ctrl.sr1_needed = 1'b1;
			ctrl.branch_stall = 1'b1;
		end
		lc3b_isa_pkg::op_lea:
		begin
			ctrl.aluop = lc3b_ctrl_pkg::alu_pass;
			ctrl.ld_reg = 1'b1;
		end
		lc3b_isa_pkg::op_trap:
		begin
			ctrl.destmux_sel = lc3b_ctrl_pkg::dest_r7;
			ctrl.ld_reg = 1'b1;
			ctrl.mem_read = 1'b1; // Vector table read.
			ctrl.branch_stall = 1'b1;
		end
		default: ;
	endcase

	// BR with no condition bits never branches.
	if (instr == 16'h0000)
	begin
		ctrl.cc_needed = 1'b0;
		ctrl.branch_stall = 1'b0;
	end
end

endmodule : control_rom

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile
(
	input logic clk,
	input logic arst_n,
	input logic load,
	input lc3b_isa_pkg::lc3b_word in,
	input lc3b_isa_pkg::lc3b_reg src_a,
	input lc3b_isa_pkg::lc3b_reg src_b,
	input lc3b_isa_pkg::lc3b_reg dest,
	output lc3b_isa_pkg::lc3b_word reg_a,
	output lc3b_isa_pkg::lc3b_word reg_b
);

lc3b_isa_pkg::lc3b_word data [lc3b_isa_pkg::num_regs];

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		for (int i = 0; i < lc3b_isa_pkg::num_regs; i++)
			data[i] <= '0;
	end
	else if (load)
	begin
		data[dest] <= in;
	end
end

// Reads see the old value during a write cycle.
always_comb
begin
	reg_a = data[src_a];
	reg_b = data[src_b];
end

// Writeback must always name a register.
dest_known: assert property (@(posedge clk) disable iff (!arst_n)
	load |-> !$isunknown(dest));

endmodule : regfile

// File: src/dep_check.sv
`timescale 1ns/1ps

module dep_check
(
	input lc3b_isa_pkg::lc3b_reg sr1,
	input lc3b_isa_pkg::lc3b_reg sr2,
	input logic valid,
	input lc3b_ctrl_pkg::lc3b_control_word cw,
	hazard_if.consumer hz,
	output logic dep_stall
);

logic ex_conflict;
logic mem_conflict;
logic wb_conflict;

// True when a register write is pending on a source this instruction reads.
function automatic logic reg_hit
(
	input logic stage_valid,
	input logic stage_ld_reg,
	input lc3b_isa_pkg::lc3b_reg drid,
	input lc3b_isa_pkg::lc3b_reg src1,
	input lc3b_isa_pkg::lc3b_reg src2,
	input logic src1_needed,
	input logic src2_needed
);
	logic hit;
	hit = (src1_needed && drid == src1) || (src2_needed && drid == src2);
	return stage_valid && stage_ld_reg && hit;
endfunction

always_comb
begin
	ex_conflict = reg_hit(hz.ex_valid, hz.ex_ld_reg, hz.ex_drid, sr1, sr2,
		cw.sr1_needed, cw.sr2_needed)
		|| (hz.ex_valid && hz.ex_ld_cc && cw.cc_needed);

	mem_conflict = reg_hit(hz.mem_valid, hz.mem_ld_reg, hz.mem_drid, sr1, sr2,
		cw.sr1_needed, cw.sr2_needed)
		|| (hz.mem_valid && hz.mem_ld_cc && cw.cc_needed);

	wb_conflict = reg_hit(hz.wb_valid, hz.wb_ld_reg, hz.wb_drid, sr1, sr2,
		cw.sr1_needed, cw.sr2_needed)
		|| (hz.wb_valid && hz.wb_ld_cc && cw.cc_needed);
end

assign dep_stall = valid && (ex_conflict || mem_conflict || wb_conflict);

// A stall always traces to a live downstream stage.
stall_has_source: assert property (@(posedge hz.clk)
	dep_stall |-> (hz.ex_valid || hz.mem_valid || hz.wb_valid));

endmodule : dep_check

// File: src/decode.sv
`timescale 1ns/1ps

module decode
(
	input logic clk,
	input logic arst_n,
	input lc3b_isa_pkg::lc3b_word npc_in,
	input lc3b_isa_pkg::lc3b_word ir_in,
	input logic valid_in,

	// Writeback port.
	input lc3b_isa_pkg::lc3b_word reg_data,
	input lc3b_isa_pkg::lc3b_nzp cc_data,
	input lc3b_isa_pkg::lc3b_reg dest_reg,

	hazard_if.consumer hz,

	input logic execute_br_stall,
	input logic execute_indirect_stall,
	input logic mem_stall,
	input logic mem_br_stall,
	input logic icache_stall,

	output lc3b_isa_pkg::lc3b_word npc,
	output lc3b_isa_pkg::lc3b_word ir,
	output lc3b_ctrl_pkg::lc3b_control_word cw,
	output lc3b_isa_pkg::lc3b_word sr1,
	output lc3b_isa_pkg::lc3b_word sr2,
	output lc3b_isa_pkg::lc3b_nzp cc_out,
	output lc3b_isa_pkg::lc3b_reg dr,
	output lc3b_isa_pkg::lc3b_reg sr1_reg,
	output lc3b_isa_pkg::lc3b_reg sr2_reg,
	output logic valid,
	output logic load_ex,
	output logic dep_stall,
	output logic decode_br_stall
);

assign npc = npc_in;
assign ir = ir_in;
assign sr1_reg = ir_in[8:6];

// Stores read their data register as source 2.
assign sr2_reg = (cw.regfilemux_sel == lc3b_ctrl_pkg::src_ir_dr) ? ir_in[11:9] : ir_in[2:0];
assign dr = (cw.destmux_sel == lc3b_ctrl_pkg::dest_r7) ? lc3b_isa_pkg::r7 : ir_in[11:9];

control_rom control_store
(
	.instr(ir_in),
	.ctrl(cw)
);

regfile regfile_int
(
	.clk,
	.arst_n,
	.load(hz.wb_ld_reg),
	.in(reg_data),
	.src_a(sr1_reg),
	.src_b(sr2_reg),
	.dest(dest_reg),
	.reg_a(sr1),
	.reg_b(sr2)
);

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		cc_out <= '0;
	else if (hz.wb_ld_cc)
		cc_out <= cc_data;
end

dep_check dep_check_int
(
	.sr1(sr1_reg),
	.sr2(sr2_reg),
	.valid(valid_in),
	.cw,
	.hz,
	.dep_stall
);

assign decode_br_stall = valid_in && cw.branch_stall;
assign valid = valid_in && !dep_stall && !execute_br_stall && !mem_br_stall;
assign load_ex = !(mem_stall || execute_indirect_stall || icache_stall); // Back-pressure.

// Condition codes never load an unknown value.
cc_known: assert property (@(posedge clk) disable iff (!arst_n)
	hz.wb_ld_cc |-> !$isunknown(cc_data));

endmodule : decode

// File: src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
(
	input logic clk,
	input logic arst_n,
	input lc3b_isa_pkg::lc3b_word npc_in,
	input lc3b_isa_pkg::lc3b_word ir_in,
	input logic valid_in,
	input lc3b_isa_pkg::lc3b_word reg_data,
	input lc3b_isa_pkg::lc3b_nzp cc_data,
	input lc3b_isa_pkg::lc3b_reg dest_reg,

	input lc3b_isa_pkg::lc3b_reg ex_drid,
	input logic ex_ld_reg,
	input logic ex_ld_cc,
	input logic ex_valid,
	input lc3b_isa_pkg::lc3b_reg mem_drid,
	input logic mem_ld_reg,
	input logic mem_ld_cc,
	input logic mem_valid,
	input lc3b_isa_pkg::lc3b_reg wb_drid,
	input logic wb_ld_reg,
	input logic wb_ld_cc,
	input logic wb_valid,

	input logic execute_br_stall,
	input logic execute_indirect_stall,
	input logic mem_stall,
	input logic mem_br_stall,
	input logic icache_stall,

	output lc3b_isa_pkg::lc3b_word npc,
	output lc3b_isa_pkg::lc3b_word ir,
	output lc3b_ctrl_pkg::lc3b_control_word cw,
	output lc3b_isa_pkg::lc3b_word sr1,
	output lc3b_isa_pkg::lc3b_word sr2,
	output lc3b_isa_pkg::lc3b_nzp cc_out,
	output lc3b_isa_pkg::lc3b_reg dr,
	output lc3b_isa_pkg::lc3b_reg sr1_reg,
	output lc3b_isa_pkg::lc3b_reg sr2_reg,
	output logic valid,
	output logic load_ex,
	output logic dep_stall,
	output logic decode_br_stall
);

hazard_if hz (.clk);

// Downstream status onto the hazard bundle.
assign hz.ex_drid = ex_drid;
assign hz.ex_ld_reg = ex_ld_reg;
assign hz.ex_ld_cc = ex_ld_cc;
assign hz.ex_valid = ex_valid;
assign hz.mem_drid = mem_drid;
assign hz.mem_ld_reg = mem_ld_reg;
assign hz.mem_ld_cc = mem_ld_cc;
assign hz.mem_valid = mem_valid;
assign hz.wb_drid = wb_drid;
assign hz.wb_ld_reg = wb_ld_reg;
assign hz.wb_ld_cc = wb_ld_cc;
assign hz.wb_valid = wb_valid;

decode decode_int
(
	.clk,
	.arst_n,
	.npc_in,
	.ir_in,
	.valid_in,
	.reg_data,
	.cc_data,
	.dest_reg,
	.hz(hz.consumer),
	.execute_br_stall,
	.execute_indirect_stall,
	.mem_stall,
	.mem_br_stall,
	.icache_stall,
	.npc,
	.ir,
	.cw,
	.sr1,
	.sr2,
	.cc_out,
	.dr,
	.sr1_reg,
	.sr2_reg,
	.valid,
	.load_ex,
	.dep_stall,
	.decode_br_stall
);

endmodule : decode_unit

// File: sim/decode_unit_tb.sv
`timescale 1ns/1ps

module decode_unit_tb;

localparam int clk_period = 100;
localparam int num_tests = 6;
localparam int cycles_per_test = 40;
localparam int watchdog_ns = num_tests * cycles_per_test * clk_period * 5 / 2; // 60 us.

logic clk = 1'b0;
logic arst_n, valid_in, valid, load_ex, dep_stall, decode_br_stall;
logic ex_ld_reg, ex_ld_cc, ex_valid, mem_ld_reg, mem_ld_cc, mem_valid;
logic wb_ld_reg, wb_ld_cc, wb_valid;
logic execute_br_stall, execute_indirect_stall, mem_stall, mem_br_stall, icache_stall;
lc3b_isa_pkg::lc3b_word npc_in, ir_in, reg_data, npc, ir, sr1, sr2;
lc3b_isa_pkg::lc3b_nzp cc_data, cc_out;
lc3b_isa_pkg::lc3b_reg dest_reg, ex_drid, mem_drid, wb_drid, dr, sr1_reg, sr2_reg;
lc3b_ctrl_pkg::lc3b_control_word cw;
lc3b_isa_pkg::lc3b_word vals [8];

decode_unit UUT (.*);

always #(clk_period / 2) clk = ~clk;

initial
begin
	#(watchdog_ns);
	$display("Timeout: the decode tests did not finish in time.");
	$display("Simulation FAILED");
	$fatal(1);
end

task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
	assert (got === exp)
	else
	begin
		$display("[FAIL] %s = %h, expected %h", name, got, exp);
		$display("Simulation FAILED");
		$fatal(1);
	end
endtask

function automatic lc3b_isa_pkg::lc3b_word add_reg(input logic [2:0] d, s1, s2);
	return {4'b0001, d, s1, 3'b000, s2};
endfunction

task automatic quiet_inputs();
	{ex_valid, ex_ld_reg, ex_ld_cc, ex_drid} <= '0;
	{mem_valid, mem_ld_reg, mem_ld_cc, mem_drid} <= '0;
	{wb_valid, wb_ld_reg, wb_ld_cc, wb_drid} <= '0;
	{execute_br_stall, execute_indirect_stall, mem_stall, mem_br_stall, icache_stall} <= '0;
endtask

task automatic set_stage(input int stage, input logic v, ldr, ldc, input logic [2:0] drid);
	case (stage)
		0: {ex_valid, ex_ld_reg, ex_ld_cc, ex_drid} <= {v, ldr, ldc, drid};
		1: {mem_valid, mem_ld_reg, mem_ld_cc, mem_drid} <= {v, ldr, ldc, drid};
		default: {wb_valid, wb_ld_reg, wb_ld_cc, wb_drid} <= {v, ldr, ldc, drid};
	endcase
endtask

task automatic issue(input lc3b_isa_pkg::lc3b_word instr, input logic v);
	ir_in <= instr;
	valid_in <= v;
	npc_in <= 16'($urandom);
endtask

// Outputs are combinational, so sample them mid-cycle.
task automatic settle();
	@(negedge clk);
	check_value("ir", ir, ir_in);
	check_value("npc", npc, npc_in);
endtask

// Expected flow signals from the stage rules.
task automatic check_flow(input logic conflict, input logic is_branch);
	logic exp_dep;
	logic exp_valid;
	logic exp_load;
	exp_dep = valid_in && conflict;
	exp_valid = valid_in && !exp_dep && !execute_br_stall && !mem_br_stall;
	exp_load = !(mem_stall || execute_indirect_stall || icache_stall);
	check_value("dep_stall", dep_stall, exp_dep);
	check_value("valid", valid, exp_valid);
	check_value("load_ex", load_ex, exp_load);
	check_value("decode_br_stall", decode_br_stall, valid_in && is_branch);
endtask

task automatic apply_reset();
	@(posedge clk);
	arst_n <= 1'b0;
	valid_in <= 1'b0;
	repeat (5) @(posedge clk);
	arst_n <= 1'b1;
endtask

task automatic hazard_case(input lc3b_isa_pkg::lc3b_word instr, input int stage,
	input logic v, ldr, ldc, input logic [2:0] drid, input logic conflict);
	@(posedge clk);
	quiet_inputs();
	set_stage(stage, v, ldr, ldc, drid);
	issue(instr, 1'b1);
	settle();
	check_flow(conflict, instr[15:12] == 4'b0000);
endtask

task automatic test_regfile();
	for (int i = 0; i < 8; i++)
	begin
		@(posedge clk);
		vals[i] = 16'($urandom);
		reg_data <= vals[i];
		dest_reg <= 3'(i);
		wb_ld_reg <= 1'b1;
		issue(add_reg(3'd0, 3'(i), 3'(i)), 1'b1);
		settle();
		check_value("sr1", sr1, 16'h0000); // Old value until the edge.
	end
	@(posedge clk);
	wb_ld_reg <= 1'b0;
	for (int i = 0; i < 8; i++)
	begin
		@(posedge clk);
		issue(add_reg(3'd1, 3'(i), 3'(7 - i)), 1'b1);
		settle();
		check_value("sr1_reg", sr1_reg, 16'(i));
		check_value("sr2_reg", sr2_reg, 16'(7 - i));
		check_value("sr1", sr1, vals[i]);
		check_value("sr2", sr2, vals[7 - i]);
	end
endtask

task automatic test_select();
	@(posedge clk);
	quiet_inputs();
	issue(add_reg(3'd3, 3'd4, 3'd5), 1'b1);
	settle();
	check_value("sr2_reg", sr2_reg, 16'h5);
	check_value("dr", dr, 16'h3);
	check_value("cw.sr2_needed", cw.sr2_needed, 16'h1);
	@(posedge clk);
	issue({4'b0001, 3'd3, 3'd4, 1'b1, 5'h0d}, 1'b1); // ADD R3, R4, #13.
	settle();
	check_value("cw.sr2_needed", cw.sr2_needed, 16'h0);
	check_value("cw.sr1_needed", cw.sr1_needed, 16'h1);
	@(posedge clk);
	issue({4'b0111, 3'd6, 3'd2, 6'h04}, 1'b1); // STR R6, R2, #4.
	settle();
	check_value("sr2_reg", sr2_reg, 16'h6);
	check_value("cw.mem_write", cw.mem_write, 16'h1);
	check_value("cw.ld_reg", cw.ld_reg, 16'h0);
	@(posedge clk);
	issue({4'b0100, 1'b1, 11'h020}, 1'b1);
	settle();
	check_value("dr", dr, 16'h7);
	check_value("cw.branch_stall", cw.branch_stall, 16'h1);
endtask

task automatic test_hazards();
	lc3b_isa_pkg::lc3b_word add_op;
	add_op = add_reg(3'd1, 3'd2, 3'd3);
	hazard_case(add_op, 0, 1'b1, 1'b1, 1'b0, 3'd2, 1'b1);
	hazard_case(add_op, 1, 1'b1, 1'b1, 1'b0, 3'd3, 1'b1);
	hazard_case(add_op, 2, 1'b1, 1'b1, 1'b0, 3'd2, 1'b1);
	hazard_case(add_op, 0, 1'b1, 1'b1, 1'b0, 3'd5, 1'b0);
	hazard_case({4'b0001, 3'd1, 3'd2, 1'b1, 5'h03}, 0, 1'b1, 1'b1, 1'b0, 3'd3, 1'b0);
	hazard_case(add_op, 1, 1'b0, 1'b1, 1'b0, 3'd2, 1'b0); // Stage empty.
	hazard_case(add_op, 2, 1'b1, 1'b0, 1'b1, 3'd2, 1'b0);
	for (int s = 0; s < 3; s++)
		hazard_case({4'b0000, 3'b111, 9'h010}, s, 1'b1, 1'b0, 1'b1, 3'd0, 1'b1);
endtask

task automatic test_flow();
	@(posedge clk);
	quiet_inputs();
	issue({4'b0000, 3'b010, 9'h004}, 1'b1);
	settle();
	check_flow(1'b0, 1'b1);
	@(posedge clk);
	valid_in <= 1'b0;
	settle();
	check_flow(1'b0, 1'b1);
	@(posedge clk);
	issue(add_reg(3'd1, 3'd2, 3'd3), 1'b1);
	// One stall line at a time, instruction held.
	for (int k = 0; k < 5; k++)
	begin
		@(posedge clk);
		{execute_br_stall, mem_br_stall, mem_stall, execute_indirect_stall, icache_stall}
			<= 5'b10000 >> k;
		settle();
		check_flow(1'b0, 1'b0);
	end
endtask

task automatic test_noop_reset();
	@(posedge clk);
	quiet_inputs();
	for (int s = 0; s < 3; s++)
		set_stage(s, 1'b1, 1'b1, 1'b1, 3'd0);
	cc_data <= 3'b101;
	issue(16'h0000, 1'b1);
	settle();
	check_flow(1'b0, 1'b0);
	check_value("cw flags", {cw.ld_reg, cw.ld_cc, cw.mem_read, cw.mem_write,
		cw.branch_stall, cw.cc_needed}, 16'h0);
	@(posedge clk);
	quiet_inputs();
	settle();
	check_value("cc_out", cc_out, 16'h5);
	apply_reset();
	settle();
	check_value("cc_out", cc_out, 16'h0);
	check_value("sr1", sr1, 16'h0000);
	check_flow(1'b0, 1'b0);
endtask

task automatic test_cc();
	@(posedge clk);
	cc_data <= 3'b010;
	settle();
	check_value("cc_out", cc_out, 16'h0);
	@(posedge clk);
	wb_ld_cc <= 1'b1;
	settle();
	check_value("cc_out", cc_out, 16'h0); // Loads on the next edge.
	@(posedge clk);
	wb_ld_cc <= 1'b0;
	cc_data <= 3'b001;
	settle();
	check_value("cc_out", cc_out, 16'h2);
	@(posedge clk);
	settle();
	check_value("cc_out", cc_out, 16'h2);
endtask

initial
begin
	void'($urandom(32'h6b23));
	{arst_n, valid_in, npc_in, ir_in, reg_data, cc_data, dest_reg} = '0;
	quiet_inputs();
	apply_reset();
	test_regfile();
	test_select();
	test_hazards();
	test_flow();
	test_noop_reset();
	test_cc();
	$display("Simulation PASSED");
	$finish;
end

endmodule : decode_unit_tb

// File: build.f
src/lc3b_isa_pkg.sv
src/lc3b_ctrl_pkg.sv
src/hazard_if.sv
src/control_rom.sv
src/regfile.sv
src/dep_check.sv
src/decode.sv
src/decode_unit.sv
sim/decode_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode testbench; exit status follows the simulation.
verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module decode_unit_tb --Mdir obj_dir -o decode_unit_sim \
	&& ./obj_dir/decode_unit_sim \
	|| exit 1
